// ==== brick_pkg.sv ====
package brick_pkg;

	localparam int screen_w = 160;
	localparam int screen_h = 120;

	typedef logic [7:0] xcoord_t;
	typedef logic [6:0] ycoord_t;
	typedef logic [2:0] colour_t; // one bit per rgb channel
	typedef logic [5:0] brick_idx_t;

	localparam colour_t colour_black  = 3'd0;
	localparam colour_t colour_paddle = 3'd7; // white
	localparam colour_t colour_ball   = 3'd4; // red

	localparam int brick_count    = 40;
	localparam int bricks_per_row = 10;
	localparam int brick_w        = 16;
	localparam int brick_h        = 4;
	localparam int brick_pitch_y  = 8; // one blank band of 4 rows between brick rows

	localparam int paddle_y       = 115;
	localparam int paddle_hit_y   = 110;
	localparam int ball_size      = 2;
	localparam int ball_start_x   = 88;
	localparam int ball_start_y   = 98;
	localparam int paddle_start_x = 80;

	localparam int paddle_frames = 2;
	localparam int ball_frames   = 1;

	typedef struct packed
	{
		colour_t colour;
		ycoord_t y;
		xcoord_t x;
	} brick_t;

	typedef enum logic [3:0]
	{
		clear_screen, fill_store, draw_bricks,
		erase_paddle, move_paddle, draw_paddle,
		idle,
		erase_ball, detect_hit, write_back, erase_brick, move_ball, draw_ball
	} phase_t;

	typedef struct packed
	{
		phase_t phase;
		logic [14:0] step; // cycle within the phase
	} seq_cmd_t;

	typedef struct packed
	{
		logic valid;
		brick_idx_t index;
		brick_t brick;
	} brick_rd_t;

	typedef struct packed
	{
		logic valid;
		brick_idx_t index;
		brick_t brick;
	} hit_t;

	typedef struct packed
	{
		xcoord_t x;
		ycoord_t y;
		colour_t colour;
	} pixel_t;

endpackage

// ==== game_sequencer.sv ====
`timescale 1ns/1ps

module game_sequencer #(
	parameter int frame_cycles = 833333
) (
	input  logic clk,
	input  logic resetn,
	output brick_pkg::seq_cmd_t cmd
);

	localparam int timer_w = $clog2(frame_cycles);

	brick_pkg::phase_t phase, next_phase;
	logic [14:0] step;
	logic last_step;

	logic [timer_w-1:0] timer;
	logic frame_end;
	logic [3:0] paddle_cnt, ball_cnt;
	logic paddle_tick, ball_tick;
	logic paddle_pend, ball_pend;
	logic take_paddle, take_ball;

	// cycles spent in each phase
	function automatic logic [14:0] phase_len(input brick_pkg::phase_t p);
		case (p)
			brick_pkg::clear_screen: phase_len = 15'(brick_pkg::screen_w * brick_pkg::screen_h);
			brick_pkg::fill_store:   phase_len = 15'(brick_pkg::brick_count);
			brick_pkg::draw_bricks:  phase_len = 15'(brick_pkg::brick_count * 64);
			brick_pkg::detect_hit:   phase_len = 15'(brick_pkg::brick_count + 1); // last read returns
			brick_pkg::erase_ball, brick_pkg::draw_ball:
				phase_len = 15'(brick_pkg::ball_size * brick_pkg::ball_size);
			brick_pkg::erase_paddle, brick_pkg::draw_paddle, brick_pkg::erase_brick:
				phase_len = 15'(brick_pkg::brick_w * brick_pkg::brick_h);
			default: phase_len = 15'd1;
		endcase
	endfunction

	assign last_step = (step == phase_len(phase) - 15'd1);
	assign frame_end = (timer == timer_w'(frame_cycles - 1));
	assign paddle_tick = frame_end && (paddle_cnt == 4'(brick_pkg::paddle_frames - 1));
	assign ball_tick = frame_end && (ball_cnt == 4'(brick_pkg::ball_frames - 1));

	// paddle wins when both are pending
	assign take_paddle = (phase == brick_pkg::idle) && paddle_pend;
	assign take_ball = (phase == brick_pkg::idle) && !paddle_pend && ball_pend;

	always_comb
	begin
		case (phase)
			brick_pkg::clear_screen: next_phase = brick_pkg::fill_store;
			brick_pkg::fill_store:   next_phase = brick_pkg::draw_bricks;
			brick_pkg::draw_bricks:  next_phase = brick_pkg::draw_paddle;
			brick_pkg::erase_paddle: next_phase = brick_pkg::move_paddle;
			brick_pkg::move_paddle:  next_phase = brick_pkg::draw_paddle;
			brick_pkg::erase_ball:   next_phase = brick_pkg::detect_hit;
			brick_pkg::detect_hit:   next_phase = brick_pkg::write_back;
			brick_pkg::write_back:   next_phase = brick_pkg::erase_brick;
			brick_pkg::erase_brick:  next_phase = brick_pkg::move_ball;
			brick_pkg::move_ball:    next_phase = brick_pkg::draw_ball;
			default:                 next_phase = brick_pkg::idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			phase <= brick_pkg::clear_screen;
			step <= '0;
		end
		else if (phase == brick_pkg::idle)
		begin
			step <= '0;
			if (take_paddle)
				phase <= brick_pkg::erase_paddle;
			else if (take_ball)
				phase <= brick_pkg::erase_ball;
		end
		else if (last_step)
		begin
			phase <= next_phase;
			step <= '0;
		end
		else
			step <= step + 15'd1;
	end

	// frame timer and per-object frame dividers
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			timer <= '0;
			paddle_cnt <= '0;
			ball_cnt <= '0;
			paddle_pend <= 1'b0;
			ball_pend <= 1'b0;
		end
		else
		begin
			timer <= frame_end ? '0 : timer + 1'b1;
			if (frame_end)
			begin
				paddle_cnt <= paddle_tick ? 4'd0 : paddle_cnt + 4'd1;
				ball_cnt <= ball_tick ? 4'd0 : ball_cnt + 4'd1;
			end
			paddle_pend <= (paddle_pend && !take_paddle) || paddle_tick; // held while busy
			ball_pend <= (ball_pend && !take_ball) || ball_tick;
		end
	end

	assign cmd = '{phase: phase, step: step};

endmodule

// ==== brick_store.sv ====
`timescale 1ns/1ps

module brick_store (
	input  logic clk,
	input  logic resetn,
	input  brick_pkg::seq_cmd_t cmd,
	input  brick_pkg::hit_t hit,
	output brick_pkg::brick_rd_t rd
);

	brick_pkg::brick_t mem [brick_pkg::brick_count];

	brick_pkg::brick_idx_t rd_addr, wr_addr;
	brick_pkg::brick_t wr_data, fill_brick;
	logic rd_en, wr_en;

	logic rd_valid;
	brick_pkg::brick_idx_t rd_index;
	brick_pkg::brick_t rd_brick;

	// each brick is read for all 64 of its pixels while drawing
	assign rd_addr = (cmd.phase == brick_pkg::draw_bricks) ? cmd.step[11:6] : cmd.step[5:0];
	assign rd_en = ((cmd.phase == brick_pkg::draw_bricks) || (cmd.phase == brick_pkg::detect_hit))
		&& (rd_addr < 6'(brick_pkg::brick_count));

	// initial layout, 10 per row, colours cycle 1..7
	always_comb
	begin
		fill_brick.x = 8'(brick_pkg::brick_w * (int'(rd_addr) % brick_pkg::bricks_per_row));
		fill_brick.y = 7'(brick_pkg::brick_pitch_y * (int'(rd_addr) / brick_pkg::bricks_per_row));
		fill_brick.colour = 3'((int'(rd_addr) % 7) + 1);
	end

	always_comb
	begin
		wr_en = 1'b0;
		wr_addr = rd_addr;
		wr_data = fill_brick;
		if (cmd.phase == brick_pkg::fill_store)
			wr_en = 1'b1;
		else if (cmd.phase == brick_pkg::write_back && hit.valid)
		begin
			wr_en = 1'b1;
			wr_addr = hit.index;
			wr_data = '{colour: brick_pkg::colour_black, y: hit.brick.y, x: hit.brick.x};
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_brick <= mem[rd_addr];
		rd_index <= rd_addr;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	assign rd = '{valid: rd_valid, index: rd_index, brick: rd_brick};

endmodule

// ==== motion_unit.sv ====
`timescale 1ns/1ps

module motion_unit (
	input  logic clk,
	input  logic resetn,
	input  brick_pkg::seq_cmd_t cmd,
	input  brick_pkg::xcoord_t paddle_in,
	input  brick_pkg::brick_rd_t rd,
	output brick_pkg::hit_t hit,
	output brick_pkg::xcoord_t paddle_x,
	output brick_pkg::xcoord_t ball_x,
	output brick_pkg::ycoord_t ball_y
);

	localparam int paddle_max = brick_pkg::screen_w - brick_pkg::brick_w; // paddle is brick sized
	localparam int x_max = brick_pkg::screen_w - brick_pkg::ball_size;
	localparam int y_max = brick_pkg::screen_h - brick_pkg::ball_size - 1;

	logic dir_x, dir_y; // 1 = right / down
	logic hit_valid;
	brick_pkg::brick_idx_t hit_index;
	brick_pkg::brick_t hit_brick;

	logic [8:0] bx_l, bx_r, rx_l, rx_r; // left edge and one past the right edge
	logic [7:0] by_t, by_b, ry_t, ry_b;
	logic x_overlap, y_overlap, on_paddle;
	logic from_above, from_below, from_left, from_right;
	logic take;

	assign bx_l = {1'b0, ball_x};
	assign bx_r = bx_l + 9'(brick_pkg::ball_size);
	assign rx_l = {1'b0, rd.brick.x};
	assign rx_r = rx_l + 9'(brick_pkg::brick_w);
	assign by_t = {1'b0, ball_y};
	assign by_b = by_t + 8'(brick_pkg::ball_size);
	assign ry_t = {1'b0, rd.brick.y};
	assign ry_b = ry_t + 8'(brick_pkg::brick_h);

	assign x_overlap = (bx_r > rx_l) && (bx_l < rx_r);
	assign y_overlap = (by_b > ry_t) && (by_t < ry_b);
	assign from_above = (by_b == ry_t) && x_overlap;
	assign from_below = (by_t == ry_b) && x_overlap;
	assign from_left = (bx_r == rx_l) && y_overlap;
	assign from_right = (bx_l == rx_r) && y_overlap;

	// first live brick touched wins, hit bricks are black in the store
	assign take = (cmd.phase == brick_pkg::detect_hit) && rd.valid && !hit_valid
		&& (rd.brick.colour != brick_pkg::colour_black)
		&& (from_above || from_below || from_left || from_right);

	assign on_paddle = (bx_l >= {1'b0, paddle_x})
		&& (bx_l < {1'b0, paddle_x} + 9'(brick_pkg::brick_w));

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			paddle_x <= 8'(brick_pkg::paddle_start_x);
			ball_x <= 8'(brick_pkg::ball_start_x);
			ball_y <= 7'(brick_pkg::ball_start_y);
			dir_x <= 1'b1;
			dir_y <= 1'b0;
			hit_valid <= 1'b0;
		end
		else
		begin
			if (cmd.phase == brick_pkg::move_paddle)
				paddle_x <= (paddle_in > 8'(paddle_max)) ? 8'(paddle_max) : paddle_in;

			if (cmd.phase == brick_pkg::move_ball)
			begin
				if (dir_x)
				begin
					if (ball_x == 8'(x_max))
					begin
						dir_x <= 1'b0;
						ball_x <= ball_x - 8'd1;
					end
					else
						ball_x <= ball_x + 8'd1;
				end
				else if (ball_x == 8'd0)
				begin
					dir_x <= 1'b1;
					ball_x <= 8'd1;
				end
				else
					ball_x <= ball_x - 8'd1;

				if (dir_y)
				begin
					if ((ball_y == 7'(brick_pkg::paddle_hit_y) && on_paddle) || ball_y == 7'(y_max))
					begin
						dir_y <= 1'b0;
						ball_y <= ball_y - 7'd1;
					end
					else
						ball_y <= ball_y + 7'd1;
				end
				else if (ball_y == 7'd0)
				begin
					dir_y <= 1'b1;
					ball_y <= 7'd1;
				end
				else
					ball_y <= ball_y - 7'd1;
			end

			if (cmd.phase == brick_pkg::detect_hit && cmd.step == 15'd0)
				hit_valid <= 1'b0;
			else if (take)
			begin
				hit_valid <= 1'b1;
				if (from_above)
					dir_y <= 1'b0;
				else if (from_below)
					dir_y <= 1'b1;
				else if (from_left)
					dir_x <= 1'b0;
				else
					dir_x <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			hit_index <= rd.index;
			hit_brick <= rd.brick;
		end
	end

	assign hit = '{valid: hit_valid, index: hit_index, brick: hit_brick};

endmodule

// ==== pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer (
	input  logic clk,
	input  logic resetn,
	input  brick_pkg::seq_cmd_t cmd,
	input  brick_pkg::brick_rd_t rd,
	input  brick_pkg::hit_t hit,
	input  brick_pkg::xcoord_t paddle_x,
	input  brick_pkg::xcoord_t ball_x,
	input  brick_pkg::ycoord_t ball_y,
	output brick_pkg::pixel_t pixel,
	output logic plot
);

	brick_pkg::seq_cmd_t cmd_d; // aligned with rd
	brick_pkg::pixel_t nxt;
	logic nxt_plot;
	brick_pkg::xcoord_t rect_dx, ball_dx;
	brick_pkg::ycoord_t rect_dy, ball_dy;

	// 16x4 rectangle walk and 2x2 ball walk
	assign rect_dx = {4'd0, cmd_d.step[3:0]};
	assign rect_dy = {5'd0, cmd_d.step[5:4]};
	assign ball_dx = {7'd0, cmd_d.step[0]};
	assign ball_dy = {6'd0, cmd_d.step[1]};

	always_comb
	begin
		nxt = '0;
		nxt_plot = 1'b0;
		case (cmd_d.phase)
			brick_pkg::clear_screen:
			begin
				nxt.x = 8'(cmd_d.step % 15'(brick_pkg::screen_w));
				nxt.y = 7'(cmd_d.step / 15'(brick_pkg::screen_w));
				nxt.colour = brick_pkg::colour_black;
				nxt_plot = 1'b1;
			end
			brick_pkg::draw_bricks:
			begin
				nxt.x = rd.brick.x + rect_dx;
				nxt.y = rd.brick.y + rect_dy;
				nxt.colour = rd.brick.colour;
				nxt_plot = 1'b1;
			end
			brick_pkg::draw_paddle, brick_pkg::erase_paddle:
			begin
				nxt.x = paddle_x + rect_dx;
				nxt.y = 7'(brick_pkg::paddle_y) + rect_dy;
				nxt.colour = (cmd_d.phase == brick_pkg::draw_paddle) ?
					brick_pkg::colour_paddle : brick_pkg::colour_black;
				nxt_plot = 1'b1;
			end
			brick_pkg::draw_ball, brick_pkg::erase_ball:
			begin
				nxt.x = ball_x + ball_dx;
				nxt.y = ball_y + ball_dy;
				nxt.colour = (cmd_d.phase == brick_pkg::draw_ball) ?
					brick_pkg::colour_ball : brick_pkg::colour_black;
				nxt_plot = 1'b1;
			end
			brick_pkg::erase_brick:
			begin
				nxt.x = hit.brick.x + rect_dx;
				nxt.y = hit.brick.y + rect_dy;
				nxt.colour = brick_pkg::colour_black;
				nxt_plot = hit.valid; // nothing to erase without a hit
			end
			default:
				nxt_plot = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			cmd_d <= '{phase: brick_pkg::idle, step: '0};
			pixel <= '0;
			plot <= 1'b0;
		end
		else
		begin
			cmd_d <= cmd;
			pixel <= nxt;
			plot <= nxt_plot;
		end
	end

endmodule

// ==== brick_breaker_top.sv ====
`timescale 1ns/1ps

module brick_breaker_top #(
	parameter int frame_cycles = 833333 // 60 Hz at 50 MHz
) (
	input  logic clk,
	input  logic resetn,
	input  brick_pkg::xcoord_t paddle_in,
	output brick_pkg::pixel_t pixel,
	output logic plot
);

	brick_pkg::seq_cmd_t cmd;
	brick_pkg::brick_rd_t rd;
	brick_pkg::hit_t hit;
	brick_pkg::xcoord_t paddle_x, ball_x;
	brick_pkg::ycoord_t ball_y;

	game_sequencer #(
		.frame_cycles(frame_cycles)
	) u_seq (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd)
	);

	brick_store u_store (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd),
		.hit(hit),
		.rd(rd)
	);

	motion_unit u_motion (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd),
		.paddle_in(paddle_in),
		.rd(rd),
		.hit(hit),
		.paddle_x(paddle_x),
		.ball_x(ball_x),
		.ball_y(ball_y)
	);

	pixel_writer u_writer (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd),
		.rd(rd),
		.hit(hit),
		.paddle_x(paddle_x),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.pixel(pixel),
		.plot(plot)
	);

endmodule

// ==== tb_brick_breaker.sv ====
`timescale 1ns/1ps

module tb_brick_breaker;

	localparam int frame_len = 3000;
	localparam int clear_px = 160 * 120;
	localparam int brick_px = 40 * 64;
	localparam int ball_target = 80; // first brick is reached near ball move 71
	localparam int max_cycles = clear_px + brick_px + (ball_target + 10) * frame_len;

	logic clk;
	logic resetn;
	brick_pkg::xcoord_t paddle_in;
	brick_pkg::pixel_t pixel;
	logic plot;

	logic [31:0] lfsr;
	int cur_px, prev_px; // clamped paddle inputs, newest and the one before
	int cycle = 0;
	int errors = 0;
	int plot_n, erased, ball_draws;
	logic [3:0] shadow [clear_px]; // bit 3 set = not written since reset
	logic alive [40];
	int white_cnt, white_base, red_cnt, red_x, red_y, last_x, last_y;
	int blk_cnt, org_x, org_y, brick_j;
	logic white_first, prev_black, cand_pad, cand_ball, cand_brick;

	int px, py, pc, k, bi, j_at, ex, ey, ec;
	logic in_range, game, blk_now, new_run, aligned, pad_c, ball_c, brick_c;

	brick_breaker_top #(
		.frame_cycles(frame_len)
	) uut (
		.clk(clk),
		.resetn(resetn),
		.paddle_in(paddle_in),
		.pixel(pixel),
		.plot(plot)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic in_rect(input int x, input int y, input int ox, input int oy,
		input int w, input int h);
		return x >= ox && x < ox + w && y >= oy && y < oy + h;
	endfunction

	task automatic new_paddle_input();
		logic [7:0] v;
		for (int b = 0; b < 8; b++)
		begin
			lfsr = lfsr_step(lfsr);
			v[b] = lfsr[0];
		end
		prev_px = cur_px;
		cur_px = (v > 8'd144) ? 144 : int'(v); // paddle stays on screen
		paddle_in = v;
	endtask

	task automatic bad_pixel(input string what, input int wx, input int wy, input int wc);
		errors++;
		$display("** Error at %0t: %s pixel = (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
			$time, what, px, py, pc, wx, wy, wc);
	endtask

	task automatic bad_plot(input string msg);
		errors++;
		$display("at %0t: %s, pixel (%0d,%0d) colour %0d", $time, msg, px, py, pc);
	endtask

	// expected raster and brick pixels, erase candidates
	always_comb
	begin
		px = int'(pixel.x);
		py = int'(pixel.y);
		pc = int'(pixel.colour);
		k = plot_n - clear_px;
		bi = k / 64;
		if (plot_n < clear_px)
		begin
			ex = plot_n % 160;
			ey = plot_n / 160;
			ec = 0;
		end
		else
		begin
			ex = 16 * (bi % 10) + k % 16;
			ey = 8 * (bi / 10) + (k % 64) / 16;
			ec = bi % 7 + 1;
		end
		in_range = px < 160 && py < 120;
		game = plot_n >= clear_px + brick_px;
		blk_now = plot && game && pc == 0;
		new_run = !prev_black;
		aligned = px % 16 == 0 && py % 8 == 0 && py < 32;
		j_at = (py / 8) * 10 + px / 16;
		if (new_run)
		begin
			pad_c = !white_first && px == white_base && py == 115;
			ball_c = px == last_x && py == last_y;
			brick_c = aligned ? alive[j_at] : 1'b0;
		end
		else
		begin
			pad_c = cand_pad && in_rect(px, py, org_x, org_y, 16, 4);
			ball_c = cand_ball && in_rect(px, py, org_x, org_y, 2, 2);
			brick_c = cand_brick && in_rect(px, py, org_x, org_y, 16, 4);
		end
	end

	always @(negedge clk)
	begin
		cycle <= cycle + 1;
		if (!resetn)
		begin
			for (int i = 0; i < clear_px; i++)
				shadow[i] <= 4'b1000;
			for (int j = 0; j < 40; j++)
				alive[j] <= 3'((j % 7) + 1) != 3'd0; // every filled brick is coloured
			plot_n <= 0;
			erased <= 0;
			ball_draws <= 0;
			white_cnt <= 0;
			white_base <= 0;
			white_first <= 1'b1;
			red_cnt <= 0;
			last_x <= 88; // ball start
			last_y <= 98;
			prev_black <= 1'b0;
			blk_cnt <= 0;
		end
		else
		begin
			if (blk_now)
			begin
				if (new_run)
				begin
					org_x <= px;
					org_y <= py;
					brick_j <= j_at;
				end
				cand_pad <= pad_c;
				cand_ball <= ball_c;
				cand_brick <= brick_c;
				blk_cnt <= new_run ? 1 : blk_cnt + 1;
			end
			else if (prev_black && blk_cnt == 64 && cand_brick && !cand_pad)
			begin
				alive[brick_j] <= 1'b0; // brick gone for good
				erased <= erased + 1;
			end
			prev_black <= blk_now;

			if (plot)
			begin
				plot_n <= plot_n + 1;
				if (!in_range)
					bad_plot("plot outside the screen");
				else
					shadow[py * 160 + px] <= {1'b0, pixel.colour};
				if (!game)
				begin
					assert (px == ex && py == ey && pc == ec)
					else bad_pixel(plot_n < clear_px ? "clear" : "brick", ex, ey, ec);
					assert (plot_n >= clear_px || !in_range || shadow[py * 160 + px][3])
					else bad_plot("pixel cleared twice");
				end
				else if (pc == 7)
				begin
					if (white_cnt == 0)
					begin
						assert (py == 115 && (white_first ? px == 80 : (px == cur_px || px == prev_px)))
						else bad_plot("paddle draw does not start at the paddle input");
						white_base <= px;
					end
					else
					begin
						assert (in_rect(px, py, white_base, 115, 16, 4))
						else bad_plot("paddle pixel outside the 16x4 paddle");
					end
					if (white_cnt == 63)
						white_first <= 1'b0;
					white_cnt <= (white_cnt + 1) % 64;
				end
				else if (pc == 4)
				begin
					if (red_cnt == 0)
					begin
						assert (px <= 158 && py <= 118 && (px - last_x == 1 || last_x - px == 1)
							&& (py - last_y == 1 || last_y - py == 1))
						else bad_plot("ball did not move one pixel on each axis");
						red_x <= px;
						red_y <= py;
					end
					else
					begin
						assert (in_rect(px, py, red_x, red_y, 2, 2))
						else bad_plot("ball pixel outside its 2x2 group");
					end
					if (red_cnt == 3)
					begin
						last_x <= red_x;
						last_y <= red_y;
						ball_draws <= ball_draws + 1;
					end
					red_cnt <= (red_cnt + 1) % 4;
				end
				else if (pc == 0)
				begin
					assert (pad_c || ball_c || brick_c)
					else bad_plot("black erase matches no paddle, ball or live brick");
				end
				else
					bad_plot("unexpected colour during play");
			end
		end
	end

	initial
	begin
		resetn = 1'b0;
		lfsr = 32'hc7d3_1ff7;
		cur_px = 0;
		new_paddle_input();
		prev_px = cur_px;
		repeat (16) @(posedge clk);
		#1 resetn = 1'b1;
		while (ball_draws < ball_target && cycle < max_cycles)
		begin
			@(posedge clk);
			#1;
			if (cycle % 5000 == 0)
				new_paddle_input();
		end
		if (cycle >= max_cycles)
			$display("timeout after %0d cycles with %0d ball draws", cycle, ball_draws);
		if (erased == 0)
			$display("no brick was erased during the run");
		$display("errors: %0d, bricks erased: %0d, ball draws: %0d, cycles: %0d",
			errors, erased, ball_draws, cycle);
		if (errors == 0 && erased > 0 && cycle < max_cycles)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== files.f ====
brick_pkg.sv
game_sequencer.sv
brick_store.sv
motion_unit.sv
pixel_writer.sv
brick_breaker_top.sv
tb_brick_breaker.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_brick_breaker -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failure"
